//--- include/rvseed_defines.svh
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// concurrent check sampled on the rising clock edge.
// the check is off while rst is high; the message names the failing instance.
`define RVSEED_ASSERT(name, prop, msg) \
    name: assert property (@(posedge clk) disable iff (rst) (prop)) \
        else $error("%m: %s", msg)

`endif

//--- rtl/rvseed_pkg.sv
package rvseed_pkg;

    // datapath width.
    localparam int unsigned xlen = 64;

    // bytes per word and the width of a byte offset inside a word.
    localparam int unsigned xbytes = xlen / 8;
    localparam int unsigned off_w = $clog2(xbytes);

    // shift amount width for the 64-bit shifts.
    localparam int unsigned shamt_w = $clog2(xlen);

    // data memory depth in words and its index width.
    localparam int unsigned dmem_words = 256;
    localparam int unsigned dmem_aw = $clog2(dmem_words);

    // word address as carried on the memory bus before any wrap.
    localparam int unsigned mem_aw = xlen - off_w;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_addw = 4'd1,
        op_sub  = 4'd2,
        op_sltu = 4'd3,
        op_sra  = 4'd4,
        op_and  = 4'd5,
        op_xor  = 4'd6,
        op_remu = 4'd7,
        op_beq  = 4'd8,
        op_bne  = 4'd9,
        op_load = 4'd10
    } alu_op_e;

    // width of the zero-extending loads.
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2,
        size_d = 2'd3
    } lsize_e;

    // one request into the execute stage.
    typedef struct packed {
        alu_op_e         op;
        lsize_e          size;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } exec_req_t;

endpackage

//--- rtl/rvseed_mem_if.sv
interface rvseed_mem_if import rvseed_pkg::*; ();

    logic              req_valid;
    logic              req_ready;
    logic [mem_aw-1:0] addr;
    logic              rsp_valid;
    logic [xlen-1:0]   rdata;

    modport lsu (
        output req_valid,
        output addr,
        input  req_ready,
        input  rsp_valid,
        input  rdata
    );

    modport mem (
        input  req_valid,
        input  addr,
        output req_ready,
        output rsp_valid,
        output rdata
    );

endinterface

//--- rtl/rvseed_alu.sv
module rvseed_alu import rvseed_pkg::*; (
    input  exec_req_t       req,
    output logic [xlen-1:0] result,
    output logic            flag
);

    logic [xlen-1:0] diff;
    logic [31:0]     sum_w;
    logic            div_zero;

    // the branch compares reuse the subtractor.
    assign diff     = req.src1 - req.src2;
    assign sum_w    = req.src1[31:0] + req.src2[31:0];
    assign div_zero = (req.src2 == '0);

    always_comb begin
        result = '0;
        flag   = 1'b0;
        case (req.op)
            op_add: begin
                result = req.src1 + req.src2;
            end
            op_addw: begin
                // sign-extend the 32-bit sum to the full width.
                result = {{(xlen - 32){sum_w[31]}}, sum_w};
            end
            op_sub: begin
                result = diff;
            end
            op_sltu: begin
                result = {{(xlen - 1){1'b0}}, (req.src1 < req.src2)};
            end
            op_sra: begin
                result = $signed(req.src1) >>> req.src2[shamt_w-1:0];
            end
            op_and: begin
                result = req.src1 & req.src2;
            end
            op_xor: begin
                result = req.src1 ^ req.src2;
            end
            op_remu: begin
                // remainder by zero gives back the dividend.
                if (div_zero) begin
                    result = req.src1;
                end else begin
                    result = req.src1 % req.src2;
                end
            end
            op_beq: begin
                result = diff;
                flag   = (diff == '0);
            end
            op_bne: begin
                result = diff;
                flag   = (diff != '0);
            end
            default: begin
                // op_load and the spare codes.
                result = '0;
                flag   = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/rvseed_lsu.sv
`include "rvseed_defines.svh"

module rvseed_lsu import rvseed_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  lsize_e          size,
    output logic            done,
    output logic [xlen-1:0] data,
    rvseed_mem_if.lsu       mem
);

    typedef enum logic [1:0] {
        ls_idle,
        ls_req,
        ls_rsp
    } ls_state_e;

    ls_state_e         state;
    logic [xlen-1:0]   addr_sum;
    logic [mem_aw-1:0] word_q;
    logic [off_w-1:0]  off_q;
    lsize_e            size_q;
    logic [xlen-1:0]   lane;

    function automatic logic is_aligned(logic [off_w-1:0] off, lsize_e sz);
        case (sz)
            size_b:  return 1'b1;
            size_h:  return (off[0] == 1'b0);
            size_w:  return (off[1:0] == 2'b00);
            default: return (off == '0);
        endcase
    endfunction

    // byte address of the load.
    assign addr_sum = src1 + src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ls_idle;
        end else begin
            case (state)
                ls_idle: begin
                    if (start) begin
                        state <= ls_req;
                    end
                end
                ls_req: begin
                    if (mem.req_ready) begin
                        state <= ls_rsp;
                    end
                end
                ls_rsp: begin
                    if (mem.rsp_valid) begin
                        state <= ls_idle;
                    end
                end
                default: begin
                    state <= ls_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            word_q <= addr_sum[xlen-1:off_w];
            off_q  <= addr_sum[off_w-1:0];
            size_q <= size;
        end
    end

    // request is held until the memory takes it.
    assign mem.req_valid = (state == ls_req);
    assign mem.addr      = word_q;

    // shift the addressed lane down to bit 0.
    assign lane = mem.rdata >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            size_b:  data = {{(xlen - 8){1'b0}}, lane[7:0]};
            size_h:  data = {{(xlen - 16){1'b0}}, lane[15:0]};
            size_w:  data = {{(xlen - 32){1'b0}}, lane[31:0]};
            default: data = lane;
        endcase
    end

    assign done = (state == ls_rsp) && mem.rsp_valid;

    `RVSEED_ASSERT(start_aligned, start |-> is_aligned(addr_sum[off_w-1:0], size),
        "misaligned load address");
    `RVSEED_ASSERT(start_when_idle, start |-> state == ls_idle,
        "load started while the previous one is in flight");

endmodule

//--- rtl/rvseed_dmem.sv
`include "rvseed_defines.svh"

module rvseed_dmem import rvseed_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic [dmem_aw-1:0] wr_addr,
    input  logic [xlen-1:0]    wr_data,
    rvseed_mem_if.mem          bus
);

    logic [xlen-1:0]    mem_q [dmem_words];
    logic               rd_take;
    logic [dmem_aw-1:0] rd_idx;

    // the preload port owns the array for its cycle.
    assign bus.req_ready = !wr_en;
    assign rd_take       = bus.req_valid && bus.req_ready;

    // addresses past the top wrap onto the low bits.
    assign rd_idx = bus.addr[dmem_aw-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            bus.rdata <= mem_q[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= rd_take;
        end
    end

    // a request seen by the memory must not move before it is taken.
    `RVSEED_ASSERT(req_held, bus.req_valid && !bus.req_ready |=>
        bus.req_valid && $stable(bus.addr), "read request changed before acceptance");

endmodule

//--- rtl/rvseed_exec.sv
`include "rvseed_defines.svh"

module rvseed_exec import rvseed_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  exec_req_t       in_req,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_result,
    output logic            out_flag,
    rvseed_mem_if.lsu       mem
);

    typedef enum logic [1:0] {
        st_idle,
        st_load_wait,
        st_hold
    } exec_state_e;

    exec_state_e     state;
    logic            pend_q;
    exec_req_t       req_q;
    logic            accept;
    logic            is_load;
    logic            lsu_start;
    logic            lsu_done;
    logic [xlen-1:0] lsu_data;
    logic [xlen-1:0] alu_result;
    logic            alu_flag;
    logic [xlen-1:0] result_q;
    logic            flag_q;

    assign in_ready = (state == st_idle) && !pend_q;
    assign accept   = in_valid && in_ready;
    assign is_load  = (req_q.op == op_load);

    // the registered request is dispatched one cycle after it was taken.
    assign lsu_start = pend_q && is_load;

    rvseed_alu i_alu (
        .req    (req_q),
        .result (alu_result),
        .flag   (alu_flag)
    );

    rvseed_lsu i_lsu (
        .clk   (clk),
        .rst   (rst),
        .start (lsu_start),
        .src1  (req_q.src1),
        .src2  (req_q.src2),
        .size  (req_q.size),
        .done  (lsu_done),
        .data  (lsu_data),
        .mem   (mem)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            pend_q <= 1'b0;
        end else begin
            pend_q <= accept;
            case (state)
                st_idle: begin
                    if (pend_q) begin
                        state <= is_load ? st_load_wait : st_hold;
                    end
                end
                st_load_wait: begin
                    if (lsu_done) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= in_req;
        end
        if (pend_q && !is_load) begin
            result_q <= alu_result;
            flag_q   <= alu_flag;
        end else if (state == st_load_wait && lsu_done) begin
            result_q <= lsu_data;
            flag_q   <= 1'b0;
        end
    end

    assign out_valid  = (state == st_hold);
    assign out_result = result_q;
    assign out_flag   = flag_q;

    `RVSEED_ASSERT(out_stable, out_valid && !out_ready |=>
        out_valid && $stable(out_result) && $stable(out_flag), "result moved under back-pressure");
    `RVSEED_ASSERT(done_in_wait, lsu_done |-> state == st_load_wait,
        "load unit finished with no load outstanding");

endmodule

//--- rtl/rvseed_exec_top.sv
module rvseed_exec_top import rvseed_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  alu_op_e            in_op,
    input  lsize_e             in_size,
    input  logic [xlen-1:0]    in_src1,
    input  logic [xlen-1:0]    in_src2,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [xlen-1:0]    out_result,
    output logic               out_flag,
    input  logic               wr_en,
    input  logic [dmem_aw-1:0] wr_addr,
    input  logic [xlen-1:0]    wr_data
);

    exec_req_t in_req;

    assign in_req = '{op: in_op, size: in_size, src1: in_src1, src2: in_src2};

    // read path between the load unit and the data memory.
    rvseed_mem_if i_mem_if ();

    rvseed_exec i_exec (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_flag   (out_flag),
        .mem        (i_mem_if.lsu)
    );

    rvseed_dmem i_dmem (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .bus     (i_mem_if.mem)
    );

endmodule

//--- testbench/tb_rvseed_exec.sv
module tb_rvseed_exec import rvseed_pkg::*; ();

    localparam int num_requests   = 400;
    localparam int timeout_cycles = 200;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            flag;
    } expect_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    alu_op_e            in_op;
    lsize_e             in_size;
    logic [xlen-1:0]    in_src1;
    logic [xlen-1:0]    in_src2;
    logic               out_valid;
    logic               out_ready;
    logic [xlen-1:0]    out_result;
    logic               out_flag;
    logic               wr_en;
    logic [dmem_aw-1:0] wr_addr;
    logic [xlen-1:0]    wr_data;

    integer          seed;
    logic [xlen-1:0] mem_model [dmem_words];
    expect_t         exp_q [$];
    int              checked;
    int              cycle_cnt;
    int              acc_cycle;
    logic            acc_load;
    logic            was_valid;
    logic            was_stalled;
    logic [xlen-1:0] held_result;
    logic            held_flag;
    int              stall_left;

    rvseed_exec_top i_rvseed_exec_top (.*);

    always #2 clk = ~clk;

    task automatic stop_failed();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [xlen-1:0] expected,
                                input logic [xlen-1:0] actual);
        $display("ERROR at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
        stop_failed();
    endtask

    task automatic report_problem(input string what);
        $display("%s (time %0t)", what, $time);
        stop_failed();
    endtask

    function automatic logic [xlen-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // expected outcome of one request, from the operation rules.
    function automatic expect_t model_request(alu_op_e op, lsize_e size,
                                              logic [xlen-1:0] a, logic [xlen-1:0] b);
        expect_t         e;
        logic [xlen-1:0] sum;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] lane;
        e.result = '0;
        e.flag   = 1'b0;
        sum      = a + b;
        case (op)
            op_add:  e.result = sum;
            op_addw: e.result = {{32{sum[31]}}, sum[31:0]};
            op_sub:  e.result = a - b;
            op_sltu: e.result = (a < b) ? 64'd1 : 64'd0;
            op_sra:  e.result = $signed(a) >>> b[5:0];
            op_and:  e.result = a & b;
            op_xor:  e.result = a ^ b;
            op_remu: e.result = (b == 0) ? a : a % b;
            op_beq: begin
                e.result = a - b;
                e.flag   = (a == b);
            end
            op_bne: begin
                e.result = a - b;
                e.flag   = (a != b);
            end
            default: begin
                // a load reads its word with the index wrapped on the memory depth.
                addr = sum;
                lane = mem_model[(addr >> 3) % dmem_words] >> (8 * addr[2:0]);
                case (size)
                    size_b:  e.result = lane & 64'hff;
                    size_h:  e.result = lane & 64'hffff;
                    size_w:  e.result = lane & 64'hffff_ffff;
                    default: e.result = lane;
                endcase
            end
        endcase
        return e;
    endfunction

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!in_ready) begin
            n++;
            if (n >= timeout_cycles) begin
                report_problem("timed out waiting for in_ready");
            end
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin : check_outputs
        expect_t e;
        int      lat;
        if (rst) begin
            was_valid   = 1'b0;
            was_stalled = 1'b0;
        end else begin
            cycle_cnt = cycle_cnt + 1;
            // out_valid rose on the previous edge.
            if (out_valid && !was_valid) begin
                lat = cycle_cnt - 1 - acc_cycle;
                if (acc_load) begin
                    assert (lat >= 3) else report_problem("load result arrived too early");
                end else begin
                    assert (lat == 1) else report_value("out_valid latency", 1, lat);
                end
            end
            if (was_stalled) begin
                assert (out_valid) else report_problem("out_valid dropped under back-pressure");
                assert (out_result == held_result)
                    else report_value("out_result", held_result, out_result);
                assert (out_flag == held_flag) else report_value("out_flag", held_flag, out_flag);
            end
            if (out_valid) begin
                assert (!in_ready) else report_problem("in_ready high while a result is held");
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0) else report_problem("result with no request outstanding");
                e = exp_q.pop_front();
                assert (out_result == e.result) else report_value("out_result", e.result, out_result);
                assert (out_flag == e.flag) else report_value("out_flag", e.flag, out_flag);
                checked++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_request(in_op, in_size, in_src1, in_src2));
                acc_cycle = cycle_cnt;
                acc_load  = (in_op == op_load);
            end
            was_valid   = out_valid;
            was_stalled = out_valid && !out_ready;
            held_result = out_result;
            held_flag   = out_flag;
        end
    end

    // random back-pressure with occasional longer stalls.
    always @(posedge clk) begin : drive_ready
        logic [31:0] rr;
        rr = $random(seed);
        #1;
        if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
        end else begin
            if (rr[3:0] == 4'd0) begin
                stall_left = 4 + rr[6:4];
            end
            out_ready = (rr[3:0] >= 4'd4);
        end
    end

    initial begin
        int              i;
        int              k;
        logic [31:0]     r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] addr;
        alu_op_e         op;
        lsize_e          size;
        seed       = 32'hf978;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = op_add;
        in_size    = size_b;
        in_src1    = '0;
        in_src2    = '0;
        out_ready  = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        checked    = 0;
        cycle_cnt  = 0;
        acc_cycle  = 0;
        acc_load   = 1'b0;
        stall_left = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        assert (!out_valid) else report_value("out_valid", 0, out_valid);
        assert (in_ready) else report_value("in_ready", 1, in_ready);
        #1;
        for (i = 0; i < dmem_words; i++) begin
            wr_en      = 1'b1;
            wr_addr    = i[dmem_aw-1:0];
            wr_data    = rand64();
            mem_model[i] = wr_data;
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        // the first 44 requests walk every operation and every load size.
        for (i = 0; i < num_requests; i++) begin
            r    = $random(seed);
            k    = (i < 44) ? i % 11 : r[7:0] % 11;
            op   = alu_op_e'(k);
            size = (i < 44) ? lsize_e'((i / 11) % 4) : lsize_e'(r[9:8]);
            a    = rand64();
            b    = rand64();
            case (op)
                op_sra: begin
                    if (i == 4 || r[10]) begin
                        a[xlen-1] = 1'b1;
                    end
                end
                op_remu: begin
                    if (i == 7 || r[11:10] == 2'd0) begin
                        b = '0;
                    end else if (r[12]) begin
                        b = b & 64'hffff;
                    end
                end
                op_beq, op_bne: begin
                    if (i == 8 || i == 9 || r[11:10] == 2'd0) begin
                        b = a;
                    end
                end
                op_load: begin
                    addr = rand64() & ~((64'd1 << size) - 1);
                    b    = addr - a;
                end
                default: begin
                end
            endcase
            if (r[15:13] == 3'd0) begin
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_op    = op;
            in_size  = size;
            in_src1  = a;
            in_src2  = b;
            wait_accept();
            #1;
            in_valid = 1'b0;
        end
        k = 0;
        while (checked < num_requests) begin
            @(posedge clk);
            #1;
            k++;
            if (k >= timeout_cycles) begin
                report_problem("timed out waiting for out_valid on the last results");
            end
        end
        if (checked == num_requests && exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_problem("result count does not match the requests issued");
        end
    end

endmodule

//--- rvseed.f
+incdir+include
rtl/rvseed_pkg.sv
rtl/rvseed_mem_if.sv
rtl/rvseed_alu.sv
rtl/rvseed_lsu.sv
rtl/rvseed_dmem.sv
rtl/rvseed_exec.sv
rtl/rvseed_exec_top.sv
testbench/tb_rvseed_exec.sv

//--- Bender.yml
package:
  name: rvseed

export_include_dirs:
  - include

sources:
  - files:
      - rtl/rvseed_pkg.sv
      - rtl/rvseed_mem_if.sv
      - rtl/rvseed_alu.sv
      - rtl/rvseed_lsu.sv
      - rtl/rvseed_dmem.sv
      - rtl/rvseed_exec.sv
      - rtl/rvseed_exec_top.sv
  - target: test
    files:
      - testbench/tb_rvseed_exec.sv
